// ==== list.f ====
+incdir+.
wiscDataPkg.sv
wiscCtrlPkg.sv
stageIfs.sv
dataMemory.sv
memWbLatch.sv
writebackRegFile.sv
wiscBackEnd.sv
tb_wiscBackEnd.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the back end testbench with Verilator

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
	-f list.f \
	--top-module tb_wiscBackEnd \
	-Mdir "$BUILD_DIR" \
	-o simv
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$BUILD_DIR/simv" > "$LOG_FILE" 2>&1
simStatus=$?
cat "$LOG_FILE"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
fi

if grep -qx "TEST PASSED" "$LOG_FILE"; then
	exit 0
fi
echo "pass message not found in $LOG_FILE"
exit 1

// ==== tb_wiscBackEnd.sv ====
`timescale 1ns/10ps
`include "wiscDefines_defines.svh"

module tb_wiscBackEnd
	import wiscDataPkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int DIRECTED_INSTR = 6;
	localparam int PRELOAD_INSTR = 16;
	localparam int RANDOM_INSTR = 300;
	localparam int NUM_INSTR = DIRECTED_INSTR + PRELOAD_INSTR + RANDOM_INSTR;
	localparam int MARGIN_CYCLES = 200;
	localparam int WATCHDOG_CYCLES = NUM_INSTR * (`MEM_LATENCY + 3) + MARGIN_CYCLES;

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	logic regWrite;
	logic memRead;
	logic memWrite;
	logic memToReg;
	regIdx_t writeReg;
	regIdx_t rdAddrA;
	regIdx_t rdAddrB;
	word_t aluResult;
	word_t storeData;
	logic stall;
	word_t rdDataA;
	word_t rdDataB;

	// reference state, owned by the comparing process
	word_t refRegs [`NUM_REGS];
	word_t refMem [`MEM_DEPTH];
	logic slotValid;
	logic slotWrite;
	regIdx_t slotReg;
	word_t slotVal;
	int memWait;

	logic [31:0] rngState = 32'hda7d95c6;

	wiscBackEnd u_dut (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.memToReg(memToReg),
		.writeReg(writeReg),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.aluResult(aluResult),
		.storeData(storeData),
		.stall(stall),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rngState = x;
		return x;
	endfunction

	// value an accepted instruction leaves for its destination register
	function automatic word_t refResult(input logic rd, input logic wr, input logic toReg,
		input word_t alu, input word_t sdata);
		memAddr_t addr;
		word_t loaded;
		addr = alu[$bits(memAddr_t)-1:0];
		loaded = refMem[addr];
		if (wr)
			refMem[addr] = sdata;
		if (toReg && rd)
			return loaded;
		return alu;
	endfunction

	// read port as seen this cycle, pending write wins unless the slot is held
	function automatic word_t expectedRead(input regIdx_t addr, input logic held);
		if (!held && slotValid && slotWrite && (slotReg == addr))
			return slotVal;
		return refRegs[addr];
	endfunction

	task automatic checkEq(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("FAIL %s: expected %h, actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// present one instruction and hold it until stall drops
	task automatic issueInstr(input logic rw, input logic rd, input logic wr, input logic toReg,
		input regIdx_t dst, input word_t alu, input word_t sdata,
		input regIdx_t rA, input regIdx_t rB, output int stallCycles);
		int holdCount;
		@(posedge clk);
		#1;
		inValid = 1'b1;
		regWrite = rw;
		memRead = rd;
		memWrite = wr;
		memToReg = toReg;
		writeReg = dst;
		aluResult = alu;
		storeData = sdata;
		rdAddrA = rA;
		rdAddrB = rB;
		#4;
		holdCount = 0;
		while (stall) begin
			holdCount++;
			if (holdCount > `MEM_LATENCY + 4) begin
				$display("instruction was never accepted, stall stayed high");
				$display("TEST FAILED");
				$fatal(1, "stall timeout");
			end else begin
				@(posedge clk);
				#5;
			end
		end
		stallCycles = holdCount;
	endtask

	task automatic idleCycle(input regIdx_t rA, input regIdx_t rB);
		@(posedge clk);
		#1;
		inValid = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		rdAddrA = rA;
		rdAddrB = rB;
		#4;
	endtask

	// model follows the DUT one edge ahead, checked mid cycle
	always @(negedge clk) begin
		logic expStall;
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++)
				refRegs[i] = '0;
			slotValid = 1'b0;
			slotWrite = 1'b0;
			slotReg = '0;
			slotVal = '0;
			memWait = 0;
		end else begin
			expStall = inValid && (memRead || memWrite) && (memWait < `MEM_LATENCY);
			checkEq("stallLevel", word_t'(expStall), word_t'(stall));
			checkEq("readPortA", expectedRead(rdAddrA, expStall), rdDataA);
			checkEq("readPortB", expectedRead(rdAddrB, expStall), rdDataB);
			if (expStall) begin
				memWait++;
			end else begin
				if (slotValid && slotWrite)
					refRegs[slotReg] = slotVal;
				slotValid = inValid;
				slotWrite = inValid && regWrite;
				slotReg = writeReg;
				if (inValid) begin
					slotVal = refResult(memRead, memWrite, memToReg, aluResult, storeData);
				end
				memWait = 0;
			end
		end
	end

	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("timeout: the test sequence did not complete in %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "watchdog expired");
	end

	initial begin
		logic [31:0] r;
		logic [31:0] data;
		word_t memWord;
		int stallSeen;
		int expLen;
		rst = 1'b1;
		inValid = 1'b0;
		regWrite = 1'b0;
		memRead = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		writeReg = '0;
		rdAddrA = '0;
		rdAddrB = '0;
		aluResult = '0;
		storeData = '0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;

		// everything reads zero after reset
		for (int i = 0; i < `NUM_REGS; i++) begin
			idleCycle(regIdx_t'(i), regIdx_t'(`NUM_REGS - 1 - i));
			checkEq("resetPortA", '0, rdDataA);
			checkEq("resetPortB", '0, rdDataB);
			checkEq("resetStall", '0, word_t'(stall));
		end

		// ALU result into r3, bypass first then array
		issueInstr(1'b1, 1'b0, 1'b0, 1'b0, 3'd3, 16'h1234, '0, 3'd0, 3'd0, stallSeen);
		checkEq("aluStall", '0, word_t'(stallSeen));
		idleCycle(3'd3, 3'd3);
		checkEq("aluBypass", 16'h1234, rdDataA);
		idleCycle(3'd3, 3'd3);
		checkEq("aluHeld", 16'h1234, rdDataB);
		issueInstr(1'b0, 1'b0, 1'b0, 1'b0, 3'd3, 16'hdead, '0, 3'd3, 3'd3, stallSeen);
		idleCycle(3'd3, 3'd3);
		idleCycle(3'd3, 3'd3);
		checkEq("noWriteKeeps", 16'h1234, rdDataA);

		// store then load of the same word, upper address bits ignored
		issueInstr(1'b0, 1'b0, 1'b1, 1'b0, 3'd0, 16'h5a21, 16'hbeef, 3'd0, 3'd0, stallSeen);
		checkEq("storeStall", word_t'(`MEM_LATENCY), word_t'(stallSeen));
		issueInstr(1'b1, 1'b1, 1'b0, 1'b1, 3'd5, 16'h0021, '0, 3'd0, 3'd0, stallSeen);
		checkEq("loadStall", word_t'(`MEM_LATENCY), word_t'(stallSeen));
		idleCycle(3'd5, 3'd0);
		checkEq("loadBypass", refMem[8'h21], rdDataA);
		idleCycle(3'd5, 3'd5);
		checkEq("loadHeld", refMem[8'h21], rdDataB);

		// back to back into r2, the later one must stick
		issueInstr(1'b1, 1'b0, 1'b0, 1'b0, 3'd2, 16'h1111, '0, 3'd0, 3'd0, stallSeen);
		issueInstr(1'b1, 1'b0, 1'b0, 1'b0, 3'd2, 16'h2222, '0, 3'd2, 3'd2, stallSeen);
		checkEq("pendingBypass", 16'h1111, rdDataA);
		idleCycle(3'd2, 3'd2);
		checkEq("lastWins", 16'h2222, rdDataA);
		idleCycle(3'd2, 3'd2);
		checkEq("lastWinsHeld", 16'h2222, rdDataB);

		// fill the address window used by random loads
		for (int n = 0; n < PRELOAD_INSTR; n++) begin
			r = nextRandom();
			memWord = {r[31:24], 4'h0, 4'(n)};
			issueInstr(1'b0, 1'b0, 1'b1, 1'b0, r[4:2], memWord, r[15:0],
				r[7:5], r[10:8], stallSeen);
		end

		for (int n = 0; n < RANDOM_INSTR; n++) begin
			r = nextRandom();
			data = nextRandom();
			memWord = {r[31:24], 4'h0, r[14:11]};
			case (r[1:0])
				2'd2: issueInstr(1'b1, 1'b1, 1'b0, 1'b1, r[4:2], memWord, data[15:0],
					r[7:5], r[10:8], stallSeen);
				2'd3: issueInstr(1'b0, 1'b0, 1'b1, 1'b0, r[4:2], memWord, data[15:0],
					r[7:5], r[10:8], stallSeen);
				default: issueInstr(r[15] | r[16], 1'b0, 1'b0, 1'b0, r[4:2], r[31:16],
					data[15:0], r[7:5], r[10:8], stallSeen);
			endcase
			expLen = r[1] ? `MEM_LATENCY : 0;
			checkEq("randomStall", word_t'(expLen), word_t'(stallSeen));
			if (r[19:17] == 3'd0)
				idleCycle(r[7:5], r[10:8]);
		end

		// drain, then sweep the whole register file
		repeat (3) idleCycle(3'd0, 3'd0);
		for (int i = 0; i < `NUM_REGS; i++) begin
			idleCycle(regIdx_t'(i), regIdx_t'(`NUM_REGS - 1 - i));
			checkEq("finalPortA", refRegs[i], rdDataA);
			checkEq("finalPortB", refRegs[`NUM_REGS - 1 - i], rdDataB);
		end

		$display("TEST PASSED");
		$finish;
	end

endmodule

// ==== wiscBackEnd.sv ====
`timescale 1ns/10ps
`include "wiscDefines_defines.svh"

module wiscBackEnd
	import wiscCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input logic memToReg,
	input logic [`REG_IDX_W-1:0] writeReg,
	input logic [`REG_IDX_W-1:0] rdAddrA,
	input logic [`REG_IDX_W-1:0] rdAddrB,
	input logic [`WORD_W-1:0] aluResult,
	input logic [`WORD_W-1:0] storeData,
	output logic stall,
	output logic [`WORD_W-1:0] rdDataA,
	output logic [`WORD_W-1:0] rdDataB
);

	wbSrc_t inWbSrc;
	logic latchEn;

	memResultIf resBus ();
	memWbIf wbBus ();

	assign inWbSrc = memToReg ? wbMem : wbAlu;

	// latch freezes whenever upstream is told to hold
	assign latchEn = ~stall;

	dataMemory u_dataMemory (
		.clk(clk),
		.rst(rst),
		.inValid(inValid),
		.regWrite(regWrite),
		.memRead(memRead),
		.memWrite(memWrite),
		.wbSrc(inWbSrc),
		.writeReg(writeReg),
		.aluResult(aluResult),
		.storeData(storeData),
		.stall(stall),
		.res(resBus.source)
	);

	memWbLatch u_memWbLatch (
		.clk(clk),
		.rst(rst),
		.en(latchEn),
		.res(resBus.sink),
		.wb(wbBus.source)
	);

	writebackRegFile u_writebackRegFile (
		.clk(clk),
		.rst(rst),
		.wb(wbBus.sink),
		.rdAddrA(rdAddrA),
		.rdAddrB(rdAddrB),
		.rdDataA(rdDataA),
		.rdDataB(rdDataB)
	);

endmodule

// ==== writebackRegFile.sv ====
`timescale 1ns/10ps
`include "wiscDefines_defines.svh"

module writebackRegFile
	import wiscDataPkg::*, wiscCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	memWbIf.sink wb,
	input regIdx_t rdAddrA,
	input regIdx_t rdAddrB,
	output word_t rdDataA,
	output word_t rdDataB
);

	word_t regs [`NUM_REGS];

	word_t wbData;
	logic wrEn;

	assign wbData = (wb.wbSrc == wbMem) ? wb.readData : wb.aluResult;
	assign wrEn = wb.valid && wb.regWrite;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < `NUM_REGS; i++)
				regs[i] <= '0;
		end else if (wrEn) begin
			regs[wb.writeReg] <= wbData;
		end
	end

	// a read of the register being written sees the new word
	function automatic word_t readPort(input regIdx_t addr);
		if (wrEn && (addr == wb.writeReg))
			return wbData;
		return regs[addr];
	endfunction

	always_comb begin
		rdDataA = readPort(rdAddrA);
		rdDataB = readPort(rdAddrB);
	end

endmodule

// ==== memWbLatch.sv ====
`timescale 1ns/10ps

module memWbLatch
	import wiscDataPkg::*, wiscCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic en,
	memResultIf.sink res,
	memWbIf.source wb
);

	logic regWriteQ;
	logic validQ;
	wbSrc_t wbSrcQ;
	regIdx_t writeRegQ;
	word_t aluResultQ;
	word_t readDataQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			validQ <= 1'b0;
			regWriteQ <= 1'b0;
			wbSrcQ <= wbAlu;
			writeRegQ <= '0;
			aluResultQ <= '0;
			readDataQ <= '0;
		end else if (en) begin
			validQ <= res.valid;
			regWriteQ <= res.regWrite;
			wbSrcQ <= res.wbSrc;
			writeRegQ <= res.writeReg;
			aluResultQ <= res.aluResult;
			readDataQ <= res.readData;
		end
	end

	assign wb.valid = validQ;
	assign wb.wbSrc = wbSrcQ;
	assign wb.writeReg = writeRegQ;
	assign wb.aluResult = aluResultQ;
	assign wb.readData = readDataQ;

	// held slot becomes a bubble so the register file sees one write only
	assign wb.regWrite = en ? regWriteQ : 1'b0;

	// the memory stage must never hand over a write flag without a valid slot
	writeNeedsValid: assert property (
		@(posedge clk) disable iff (rst)
		wb.regWrite |-> wb.valid
	);

endmodule

// ==== dataMemory.sv ====
`timescale 1ns/10ps
`include "wiscDefines_defines.svh"

module dataMemory
	import wiscDataPkg::*, wiscCtrlPkg::*;
(
	input logic clk,
	input logic rst,
	input logic inValid,
	input logic regWrite,
	input logic memRead,
	input logic memWrite,
	input wbSrc_t wbSrc,
	input regIdx_t writeReg,
	input word_t aluResult,
	input word_t storeData,
	output logic stall,
	memResultIf.source res
);

	word_t memArray [`MEM_DEPTH];

	memState_t memState;
	logic [$clog2(`MEM_LATENCY+1)-1:0] latCnt;

	logic memReq;
	logic accessDone;
	logic accept;
	memAddr_t memAddr;

	assign memReq = inValid && (memRead || memWrite);
	assign memAddr = aluResult[$bits(memAddr_t)-1:0];

	// last busy cycle, the access finishes at the coming edge
	assign accessDone = (memState == memBusy) && (latCnt == '0);

	// a new request stalls right away, before the FSM has seen it
	always_comb begin
		case (memState)
			memIdle: stall = memReq;
			memBusy: stall = (latCnt != '0);
			default: stall = 1'b0;
		endcase
	end

	assign accept = inValid && !stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			memState <= memIdle;
			latCnt <= '0;
		end else begin
			case (memState)
				memIdle: begin
					if (memReq) begin
						memState <= memBusy;
						latCnt <= ($bits(latCnt))'(`MEM_LATENCY - 1);
					end
				end
				memBusy: begin
					if (latCnt == '0)
						memState <= memIdle;
					else
						latCnt <= latCnt - 1'b1;
				end
				default: memState <= memIdle;
			endcase
		end
	end

	// store lands together with the acceptance of the instruction
	always_ff @(posedge clk) begin
		if (accessDone && memWrite)
			memArray[memAddr] <= storeData;
	end

	assign res.valid = accept;
	// keep the write flag inside a valid slot only
	assign res.regWrite = regWrite && accept;
	assign res.wbSrc = wbSrc;
	assign res.writeReg = writeReg;
	assign res.aluResult = aluResult;
	assign res.readData = (accessDone && memRead) ? memArray[memAddr] : '0;

	// once raised, stall must release after the configured latency
	stallBounded: assert property (
		@(posedge clk) disable iff (rst)
		$rose(stall) |-> ##`MEM_LATENCY !stall
	);

endmodule

// ==== stageIfs.sv ====
`timescale 1ns/10ps

// memory stage result, ready to be captured by the MEM/WB latch
interface memResultIf
	import wiscDataPkg::*, wiscCtrlPkg::*;
();

	logic valid;
	logic regWrite;
	wbSrc_t wbSrc;
	regIdx_t writeReg;
	word_t aluResult;
	word_t readData;

	modport source (
		output valid,
		output regWrite,
		output wbSrc,
		output writeReg,
		output aluResult,
		output readData
	);

	modport sink (
		input valid,
		input regWrite,
		input wbSrc,
		input writeReg,
		input aluResult,
		input readData
	);

endinterface

// contents of the writeback slot
interface memWbIf
	import wiscDataPkg::*, wiscCtrlPkg::*;
();

	logic valid;
	logic regWrite;
	wbSrc_t wbSrc;
	regIdx_t writeReg;
	word_t aluResult;
	word_t readData;

	modport source (
		output valid,
		output regWrite,
		output wbSrc,
		output writeReg,
		output aluResult,
		output readData
	);

	modport sink (
		input valid,
		input regWrite,
		input wbSrc,
		input writeReg,
		input aluResult,
		input readData
	);

endinterface

// ==== wiscCtrlPkg.sv ====
package wiscCtrlPkg;

	// memory stage sequencing
	typedef enum logic {
		memIdle,
		memBusy
	} memState_t;

	// which word goes back into the register file
	typedef enum logic {
		wbAlu,
		wbMem
	} wbSrc_t;

endpackage

// ==== wiscDataPkg.sv ====
`include "wiscDefines_defines.svh"

package wiscDataPkg;

	// one datapath word
	typedef logic [`WORD_W-1:0] word_t;

	// index into the register file
	typedef logic [`REG_IDX_W-1:0] regIdx_t;

	// word address into data memory, low bits of the ALU result
	typedef logic [$clog2(`MEM_DEPTH)-1:0] memAddr_t;

endpackage

// ==== wiscDefines_defines.svh ====
`ifndef WISC_DEFINES_SVH
`define WISC_DEFINES_SVH

// datapath word, also the width of an ALU result used as address
`define WORD_W 16

// architectural register file
`define NUM_REGS 8
`define REG_IDX_W 3

// data memory size in words
`define MEM_DEPTH 256

// cycles the memory stage holds stall high for one access
`define MEM_LATENCY 2

`endif
